//--- Makefile
# Verilator build and run of the stepper controller testbench

VERILATOR ?= verilator
TOP       ?= stepper_ctrl_tb
FILELIST  ?= stepper_ctrl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- dda_axis.sv
// Accelerating DDA step generator
`timescale 1ns/1ps
`default_nettype none

module dda_axis (
  input  logic                                  CLK,
  input  logic                                  resetn,
  input  logic                                  dda_tick,
  input  logic                                  loading_move,
  input  logic                                  executing_move,
  input  logic                                  dir,
  input  logic [stepper_ctrl_pkg::DDA_BITS-1:0] increment,
  input  logic [stepper_ctrl_pkg::DDA_BITS-1:0] increment_increment,
  output logic                                  step,
  output logic [stepper_ctrl_pkg::POS_BITS-1:0] position
);
  import stepper_ctrl_pkg::*;

  logic [DDA_BITS-1:0] accum;
  logic [DDA_BITS-1:0] rate;   // Grows by increment_increment each tick
  logic [DDA_BITS:0]   sum;    // Top bit is the carry that makes a step

  assign sum = {1'b0, accum} + {1'b0, rate};

  always_ff @(posedge CLK) begin
    if (resetn) begin
      accum    <= '0;
      rate     <= '0;
      step     <= 1'b0;
      position <= '0;
    end else begin
      step <= 1'b0;
      if (loading_move) begin
        accum <= '0;
        rate  <= increment;
      end else if (dda_tick && executing_move) begin
        accum <= sum[DDA_BITS-1:0];
        rate  <= rate + increment_increment;
        step  <= sum[DDA_BITS];
        if (sum[DDA_BITS]) begin
          position <= dir ? position + 1'b1 : position - 1'b1;  // Signed count
        end
      end
    end
  end

  // Ticks are spaced by the divisor, so pulses stay apart
  a_step_single: assert property (@(posedge CLK) disable iff (resetn) step |=> !step)
    else $error("Step pulse held for more than one cycle");

endmodule

`default_nettype wire

//--- move_load_if.sv
// Decoded move bundle
`timescale 1ns/1ps
`default_nettype none

interface move_load_if;
  import stepper_ctrl_pkg::*;

  logic                                 load;         // Commit strobe, one cycle
  logic [NUM_MOTORS-1:0]                dir;
  logic [DURATION_BITS-1:0]             duration;     // In DDA ticks
  logic [NUM_MOTORS-1:0][DDA_BITS-1:0]  increment;
  logic [NUM_MOTORS-1:0][DDA_BITS-1:0]  increment_increment;
  logic                                 buffer_free;  // Write slot is empty

  modport decoder (
    output load,
    output dir,
    output duration,
    output increment,
    output increment_increment
  );

  modport sequencer (
    input  load,
    input  dir,
    input  duration,
    input  increment,
    input  increment_increment,
    output buffer_free
  );

endinterface

`default_nettype wire

//--- move_sequencer.sv
// Move buffer and DDA timing
`timescale 1ns/1ps
`default_nettype none

module move_sequencer (
  input  logic                                      CLK,
  input  logic                                      resetn,
  input  logic [stepper_ctrl_pkg::DIVISOR_BITS-1:0] divisor,
  move_load_if.sequencer                            mv,
  output logic                                      dda_tick,
  output logic                                      loading_move,
  output logic                                      executing_move,
  output logic                                      move_done,
  output logic                                      buffer_dtr,
  output logic [stepper_ctrl_pkg::NUM_MOTORS-1:0]   active_dir,
  output logic [stepper_ctrl_pkg::NUM_MOTORS-1:0][stepper_ctrl_pkg::DDA_BITS-1:0]
                                                    active_increment,
  output logic [stepper_ctrl_pkg::NUM_MOTORS-1:0][stepper_ctrl_pkg::DDA_BITS-1:0]
                                                    active_increment_increment
);
  import stepper_ctrl_pkg::*;

  // Move ring
  logic [NUM_MOTORS-1:0]               dir_buf      [BUFFER_SIZE];
  logic [DURATION_BITS-1:0]            duration_buf [BUFFER_SIZE];
  logic [NUM_MOTORS-1:0][DDA_BITS-1:0] inc_buf      [BUFFER_SIZE];
  logic [NUM_MOTORS-1:0][DDA_BITS-1:0] inc_inc_buf  [BUFFER_SIZE];

  logic [BUF_IDX_BITS-1:0]  write_idx;
  logic [BUF_IDX_BITS-1:0]  read_idx;
  logic [BUFFER_SIZE-1:0]   step_ready;     // Toggled on commit
  logic [BUFFER_SIZE-1:0]   step_finished;  // Toggled on retire
  logic                     read_slot_full;

  logic [DIVISOR_BITS-1:0]  tick_count;
  logic [DIVISOR_BITS-1:0]  tick_last;
  logic [DURATION_BITS-1:0] ticks_left;

  function automatic logic [BUF_IDX_BITS-1:0] next_idx(input logic [BUF_IDX_BITS-1:0] idx);
    if (idx == BUF_IDX_BITS'(BUFFER_SIZE - 1)) return '0;
    return idx + 1'b1;
  endfunction

  // A slot holds a move while its two toggles differ
  assign mv.buffer_free  = (step_ready[write_idx] == step_finished[write_idx]);
  assign buffer_dtr      = mv.buffer_free;
  assign read_slot_full  = (step_ready[read_idx] != step_finished[read_idx]);
  assign loading_move    = dda_tick & ~executing_move & read_slot_full;

  assign active_dir                 = dir_buf[read_idx];
  assign active_increment           = inc_buf[read_idx];
  assign active_increment_increment = inc_inc_buf[read_idx];

  assign tick_last = divisor - 1'b1;  // Divisor 0 wraps to 256 cycles

  always_ff @(posedge CLK) begin
    if (mv.load) begin
      dir_buf[write_idx]      <= mv.dir;
      duration_buf[write_idx] <= mv.duration;
      inc_buf[write_idx]      <= mv.increment;
      inc_inc_buf[write_idx]  <= mv.increment_increment;
    end
  end

  // Tick divider and write side
  always_ff @(posedge CLK) begin
    if (resetn) begin
      tick_count <= '0;
      dda_tick   <= 1'b0;
      write_idx  <= '0;
      step_ready <= '0;
    end else begin
      if (tick_count >= tick_last) begin
        tick_count <= '0;
        dda_tick   <= 1'b1;
      end else begin
        tick_count <= tick_count + 1'b1;
        dda_tick   <= 1'b0;
      end
      if (mv.load) begin
        step_ready[write_idx] <= ~step_ready[write_idx];
        write_idx             <= next_idx(write_idx);
      end
    end
  end

  // Read side and duration count
  always_ff @(posedge CLK) begin
    if (resetn) begin
      read_idx       <= '0;
      step_finished  <= '0;
      executing_move <= 1'b0;
      move_done      <= 1'b0;
      ticks_left     <= '0;
    end else begin
      move_done <= 1'b0;
      if (loading_move) begin
        executing_move <= 1'b1;
        ticks_left     <= duration_buf[read_idx];
      end else if (dda_tick && executing_move) begin
        ticks_left <= ticks_left - 1'b1;
        if (ticks_left <= DURATION_BITS'(1)) begin  // Zero duration runs one tick
          executing_move          <= 1'b0;
          move_done               <= 1'b1;
          step_finished[read_idx] <= ~step_finished[read_idx];
          read_idx                <= next_idx(read_idx);
        end
      end
    end
  end

  // Host must wait for buffer_dtr before a move header
  a_no_commit_full: assert property (@(posedge CLK) disable iff (resetn)
    mv.load |-> mv.buffer_free)
    else $error("Move committed while buffer full");

  // Retiring slot still holds the move that was executing
  a_done_after_exec: assert property (@(posedge CLK) disable iff (resetn)
    move_done |-> $past(executing_move && read_slot_full))
    else $error("move_done without an executing move");

endmodule

`default_nettype wire

//--- stepper_ctrl.f
stepper_ctrl_pkg.sv
move_load_if.sv
word_cmd_decoder.sv
move_sequencer.sv
dda_axis.sv
stepper_ctrl_top.sv
tb_clock_gen.sv
stepper_ctrl_tb.sv

//--- stepper_ctrl_pkg.sv
// Stepper controller shared definitions
`default_nettype none

package stepper_ctrl_pkg;

  // Sizes
  localparam int NUM_MOTORS    = 2;
  localparam int WORD_BITS     = 64;
  localparam int DDA_BITS      = 64;
  localparam int DURATION_BITS = 32;
  localparam int POS_BITS      = 32;
  localparam int BUFFER_SIZE   = 2;
  localparam int BUF_IDX_BITS  = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
  localparam int DIVISOR_BITS  = 8;

  // Header word plus duration plus two words per axis
  localparam int MOVE_WORDS    = 2 * NUM_MOTORS + 2;
  localparam int WORD_CNT_BITS = $clog2(MOVE_WORDS);

  localparam logic [DIVISOR_BITS-1:0] DEFAULT_CLOCK_DIVISOR = 8'd32;

  // Command bytes
  localparam logic [7:0] CMD_COORDINATED_STEP = 8'h01;
  localparam logic [7:0] CMD_MOTOR_ENABLE     = 8'h0a;
  localparam logic [7:0] CMD_MOTOR_BRAKE      = 8'h0b;
  localparam logic [7:0] CMD_CLK_DIVISOR      = 8'h20;
  localparam logic [7:0] CMD_API_VERSION      = 8'hfe;

  // API version bytes
  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd0;
  localparam logic [7:0] VERSION_DEVEL = 8'd1;

  // One host word, seen as a header or as raw data
  typedef union packed {
    struct packed {
      logic [7:0]           cmd;      // Command in the top byte
      logic [WORD_BITS-9:0] payload;  // Dir, enable, brake or divisor in low bits
    } header;
    logic [WORD_BITS-1:0] data;       // Duration or signed increment
  } cmd_word_t;

endpackage

`default_nettype wire

//--- stepper_ctrl_tb.sv
// Stepper controller testbench
`timescale 1ns/1ps
`default_nettype none

module stepper_ctrl_tb;
  import stepper_ctrl_pkg::*;

  logic                  CLK;
  logic                  resetn;
  logic [WORD_BITS-1:0]  word_data_received;
  logic                  word_received;
  logic [WORD_BITS-1:0]  word_send_data;
  logic [NUM_MOTORS-1:0] step;
  logic [NUM_MOTORS-1:0] dir;
  logic [NUM_MOTORS-1:0] enable;
  logic [NUM_MOTORS-1:0] brake;
  logic                  buffer_dtr;
  logic                  move_done;

  logic                  chk_send;   // Check readback one clock after this word
  logic [WORD_BITS-1:0]  exp_send;
  logic [NUM_MOTORS-1:0] exp_enable;
  logic [NUM_MOTORS-1:0] exp_brake;
  logic [NUM_MOTORS-1:0] exp_dir   [4];
  int                    exp_steps [4][NUM_MOTORS];
  int                    model_pos [NUM_MOTORS];  // Signed step positions
  int                    seed;

  logic                  word_received_q;
  logic                  accepted;
  logic                  seen_step0;
  int                    gap0;       // Cycles since the last axis 0 step
  int                    done_count;
  int                    step_count [NUM_MOTORS];

  tb_clock_gen clk_gen_i (
    .CLK    (CLK),
    .resetn (resetn)
  );

  stepper_ctrl_top dut_i (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .word_send_data     (word_send_data),
    .step               (step),
    .dir                (dir),
    .enable             (enable),
    .brake              (brake),
    .buffer_dtr         (buffer_dtr),
    .move_done          (move_done)
  );

  assign accepted = word_received & ~word_received_q;  // Strobe rising edge

  // Step, gap and move_done counters
  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_q <= 1'b0;
      seen_step0      <= 1'b0;
      gap0            <= 0;
      done_count      <= 0;
      for (int k = 0; k < NUM_MOTORS; k++) begin
        step_count[k] <= 0;
      end
    end else begin
      word_received_q <= word_received;
      gap0            <= step[0] ? 1 : gap0 + 1;
      if (move_done) begin
        done_count <= done_count + 1;
        seen_step0 <= 1'b0;
      end else if (step[0]) begin
        seen_step0 <= 1'b1;
      end
      for (int k = 0; k < NUM_MOTORS; k++) begin
        step_count[k] <= move_done ? 0 : step_count[k] + int'(step[k]);
      end
    end
  end

  task automatic stop_with_failure();
    $display("tests failed");
    $fatal(1, "Stopping at the first failed check");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] got);
    $display("MISMATCH %s expected %h got %h", name, expected, got);
    stop_with_failure();
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    stop_with_failure();
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] got);
    assert (got == expected) else report_mismatch(name, expected, got);
  endtask

  a_send: assert property (@(posedge CLK) disable iff (resetn)
    accepted && chk_send |=> word_send_data == exp_send)
    else report_mismatch("word_send_data", $sampled(exp_send), $sampled(word_send_data));

  a_enable: assert property (@(posedge CLK) disable iff (resetn)
    accepted |=> enable == exp_enable)
    else report_mismatch("enable", 64'($sampled(exp_enable)), 64'($sampled(enable)));

  a_brake: assert property (@(posedge CLK) disable iff (resetn)
    accepted |=> brake == exp_brake)
    else report_mismatch("brake", 64'($sampled(exp_brake)), 64'($sampled(brake)));

  // Last step of a move shares its cycle with move_done, when dir already shows the next entry
  a_dir: assert property (@(posedge CLK) disable iff (resetn)
    (|step) && !move_done |-> dir == exp_dir[done_count])
    else report_mismatch("dir", 64'($sampled(exp_dir[done_count])), 64'($sampled(dir)));

  // First move: one step per 4 ticks of 4 cycles
  a_step_gap: assert property (@(posedge CLK) disable iff (resetn)
    step[0] && seen_step0 && done_count == 0 |-> gap0 == 16)
    else report_mismatch("step[0] spacing", 64'd16, 64'($sampled(gap0)));

  a_dtr_rise: assert property (@(posedge CLK) disable iff (resetn)
    move_done && done_count == 1 |-> buffer_dtr && !$past(buffer_dtr))
    else report_mismatch("buffer_dtr", 64'd1, 64'($sampled(buffer_dtr)));

  for (genvar k = 0; k < NUM_MOTORS; k++) begin : g_axis_chk
    a_step_count: assert property (@(posedge CLK) disable iff (resetn)
      move_done |-> step_count[k] + int'(step[k]) == exp_steps[done_count][k])
      else report_mismatch($sformatf("step[%0d] count", k),
                           64'($sampled(exp_steps[done_count][k])),
                           64'($sampled(step_count[k] + int'(step[k]))));
  end

  // Carries of the accelerating DDA over a number of ticks
  function automatic int dda_steps(input logic [63:0] inc, input logic [63:0] inc_inc,
                                   input int ticks);
    logic [64:0] sum;
    logic [63:0] acc;
    logic [63:0] rate;
    int          steps;
    acc   = '0;
    rate  = inc;
    steps = 0;
    for (int t = 0; t < ticks; t++) begin
      sum   = {1'b0, acc} + {1'b0, rate};
      steps = steps + int'(sum[64]);
      acc   = sum[63:0];
      rate  = rate + inc_inc;
    end
    return steps;
  endfunction

  // Strobe high for 2 cycles, low for 2
  task automatic send_word(input logic [WORD_BITS-1:0] w, input logic chk,
                           input logic [WORD_BITS-1:0] expected);
    chk_send           <= chk;
    exp_send           <= expected;
    word_data_received <= w;
    word_received      <= 1'b1;
    repeat (2) @(posedge CLK);
    word_received <= 1'b0;
    repeat (2) @(posedge CLK);
  endtask

  task automatic wait_buffer_ready();
    int cycles;
    cycles = 0;
    while (!buffer_dtr) begin
      @(posedge CLK);
      cycles++;
      if (cycles > 4000) report_timeout("buffer_dtr");
    end
  endtask

  task automatic wait_done_count(input int n);
    int cycles;
    cycles = 0;
    while (done_count < n) begin
      @(posedge CLK);
      cycles++;
      if (cycles > 4000) report_timeout("move_done");
    end
  endtask

  task automatic send_move(input int idx, input logic [NUM_MOTORS-1:0] dirs, input int ticks,
                           input logic [NUM_MOTORS-1:0][DDA_BITS-1:0] inc,
                           input logic [NUM_MOTORS-1:0][DDA_BITS-1:0] inc_inc,
                           input logic readback);
    cmd_word_t            w;
    logic [WORD_BITS-1:0] snap [NUM_MOTORS];
    int                   steps;
    wait_buffer_ready();
    for (int k = 0; k < NUM_MOTORS; k++) begin
      snap[k]           = longint'(model_pos[k]);  // Header snapshots positions before the move
      steps             = dda_steps(inc[k], inc_inc[k], ticks);
      exp_steps[idx][k] = steps;
      model_pos[k]      = model_pos[k] + (dirs[k] ? steps : -steps);
    end
    exp_dir[idx]                     = dirs;
    w                                = '0;
    w.header.cmd                     = CMD_COORDINATED_STEP;
    w.header.payload[NUM_MOTORS-1:0] = dirs;
    send_word(w, 1'b0, '0);
    w.data = WORD_BITS'(ticks);
    send_word(w, readback, snap[0]);
    for (int k = 0; k < NUM_MOTORS; k++) begin
      send_word(inc[k], readback, snap[k]);
      send_word(inc_inc[k], readback, snap[(k + 1 < NUM_MOTORS) ? k + 1 : k]);
    end
  endtask

  initial begin
    logic [NUM_MOTORS-1:0][DDA_BITS-1:0] inc;
    logic [NUM_MOTORS-1:0][DDA_BITS-1:0] inc_inc;
    cmd_word_t                           w;
    int                                  cycles;
    seed               = 43;
    word_data_received = '0;
    word_received      = 1'b0;
    chk_send           = 1'b0;
    exp_send           = '0;
    exp_enable         = '0;
    exp_brake          = '0;
    for (int i = 0; i < 4; i++) begin
      exp_dir[i] = '0;
    end
    for (int k = 0; k < NUM_MOTORS; k++) begin
      model_pos[k] = 0;
    end

    cycles = 0;
    while (resetn !== 1'b0) begin
      @(posedge CLK);
      cycles++;
      if (cycles > 10) report_timeout("reset release");
    end
    @(posedge CLK);
    check_value("buffer_dtr", 64'd1, 64'(buffer_dtr));
    check_value("step", 64'd0, 64'(step));
    check_value("enable", 64'd0, 64'(enable));
    check_value("brake", 64'd0, 64'(brake));
    check_value("move_done", 64'd0, 64'(move_done));
    check_value("word_send_data", 64'd0, word_send_data);

    // Version, enable, brake, unknown header
    w            = '0;
    w.header.cmd = CMD_API_VERSION;
    send_word(w, 1'b1, 64'({VERSION_DEVEL, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH}));
    w.header.cmd                     = CMD_MOTOR_ENABLE;
    w.header.payload[NUM_MOTORS-1:0] = NUM_MOTORS'($random(seed));
    exp_enable                       = w.header.payload[NUM_MOTORS-1:0];
    send_word(w, 1'b0, '0);
    w.header.cmd                     = CMD_MOTOR_BRAKE;
    w.header.payload[NUM_MOTORS-1:0] = NUM_MOTORS'($random(seed));
    exp_brake                        = w.header.payload[NUM_MOTORS-1:0];
    send_word(w, 1'b0, '0);
    w            = '0;
    w.header.cmd = 8'h55;
    send_word(w, 1'b1, '0);
    w.header.cmd = CMD_CLK_DIVISOR;
    w.header.payload[DIVISOR_BITS-1:0] = DIVISOR_BITS'(4);
    send_word(w, 1'b0, '0);

    // Constant rate on axis 0 gives one carry every 4 ticks
    for (int k = 0; k < NUM_MOTORS; k++) begin
      inc[k] = {$random(seed), $random(seed)};
    end
    inc[0]  = 64'h4000_0000_0000_0000;
    inc_inc = '0;
    send_move(0, NUM_MOTORS'(2), 40, inc, inc_inc, 1'b1);
    wait_done_count(1);

    // Two moves back to back fill both slots
    for (int idx = 1; idx <= 2; idx++) begin
      for (int k = 0; k < NUM_MOTORS; k++) begin
        inc[k]     = {$random(seed), $random(seed)};
        inc_inc[k] = 64'($random(seed) & 32'h0000_ffff);
      end
      send_move(idx, NUM_MOTORS'($random(seed)), 35 - 5 * idx, inc, inc_inc, 1'b0);
    end
    check_value("buffer_dtr", 64'd0, 64'(buffer_dtr));
    wait_done_count(3);
    repeat (64) @(posedge CLK);
    check_value("move_done count", 64'd3, 64'(done_count));

    // Readback of the accumulated positions
    for (int k = 0; k < NUM_MOTORS; k++) begin
      inc[k]     = {$random(seed), $random(seed)};
      inc_inc[k] = 64'($random(seed) & 32'h0000_ffff);
    end
    send_move(3, NUM_MOTORS'(1), 10, inc, inc_inc, 1'b1);
    wait_done_count(4);
    repeat (64) @(posedge CLK);
    check_value("move_done count", 64'd4, 64'(done_count));

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- stepper_ctrl_top.sv
// Two-axis stepper controller top
`timescale 1ns/1ps
`default_nettype none

module stepper_ctrl_top (
  input  logic                                    CLK,
  input  logic                                    resetn,
  input  logic [stepper_ctrl_pkg::WORD_BITS-1:0]  word_data_received,
  input  logic                                    word_received,
  output logic [stepper_ctrl_pkg::WORD_BITS-1:0]  word_send_data,
  output logic [stepper_ctrl_pkg::NUM_MOTORS-1:0] step,
  output logic [stepper_ctrl_pkg::NUM_MOTORS-1:0] dir,
  output logic [stepper_ctrl_pkg::NUM_MOTORS-1:0] enable,
  output logic [stepper_ctrl_pkg::NUM_MOTORS-1:0] brake,
  output logic                                    buffer_dtr,
  output logic                                    move_done
);
  import stepper_ctrl_pkg::*;

  move_load_if mv_if ();

  logic [DIVISOR_BITS-1:0]             divisor;
  logic                                dda_tick;
  logic                                loading_move;
  logic                                executing_move;
  logic [NUM_MOTORS-1:0][POS_BITS-1:0] position;
  logic [NUM_MOTORS-1:0][DDA_BITS-1:0] active_increment;
  logic [NUM_MOTORS-1:0][DDA_BITS-1:0] active_increment_increment;

  word_cmd_decoder decoder_i (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .position           (position),
    .word_send_data     (word_send_data),
    .enable             (enable),
    .brake              (brake),
    .divisor            (divisor),
    .mv                 (mv_if.decoder)
  );

  move_sequencer sequencer_i (
    .CLK                        (CLK),
    .resetn                     (resetn),
    .divisor                    (divisor),
    .mv                         (mv_if.sequencer),
    .dda_tick                   (dda_tick),
    .loading_move               (loading_move),
    .executing_move             (executing_move),
    .move_done                  (move_done),
    .buffer_dtr                 (buffer_dtr),
    .active_dir                 (dir),   // Dir of the active entry
    .active_increment           (active_increment),
    .active_increment_increment (active_increment_increment)
  );

  for (genvar k = 0; k < NUM_MOTORS; k++) begin : g_axis
    dda_axis axis_i (
      .CLK                 (CLK),
      .resetn              (resetn),
      .dda_tick            (dda_tick),
      .loading_move        (loading_move),
      .executing_move      (executing_move),
      .dir                 (dir[k]),
      .increment           (active_increment[k]),
      .increment_increment (active_increment_increment[k]),
      .step                (step[k]),
      .position            (position[k])
    );
  end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic resetn
);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;  // 10 ns period
  end

  // Reset is active high, held for two clocks
  initial begin
    resetn = 1'b1;
    repeat (2) @(posedge CLK);
    resetn <= 1'b0;
  end

endmodule

`default_nettype wire

//--- word_cmd_decoder.sv
// Host command word decoder
`timescale 1ns/1ps
`default_nettype none

module word_cmd_decoder (
  input  logic                                  CLK,
  input  logic                                  resetn,
  input  stepper_ctrl_pkg::cmd_word_t           word_data_received,
  input  logic                                  word_received,
  input  logic [stepper_ctrl_pkg::NUM_MOTORS-1:0][stepper_ctrl_pkg::POS_BITS-1:0] position,
  output logic [stepper_ctrl_pkg::WORD_BITS-1:0]    word_send_data,
  output logic [stepper_ctrl_pkg::NUM_MOTORS-1:0]   enable,
  output logic [stepper_ctrl_pkg::NUM_MOTORS-1:0]   brake,
  output logic [stepper_ctrl_pkg::DIVISOR_BITS-1:0] divisor,
  move_load_if.decoder                          mv
);
  import stepper_ctrl_pkg::*;

  logic                                word_received_q;
  logic                                word_accept;
  logic                                in_move;     // Header seen, move words pending
  logic [WORD_CNT_BITS-1:0]            word_count;  // Index of the next move word
  logic [NUM_MOTORS-1:0][POS_BITS-1:0] pos_snap;    // Positions at move header

  // Positions are signed, widen to a full host word
  function automatic logic [WORD_BITS-1:0] sext_pos(input logic [POS_BITS-1:0] p);
    return {{(WORD_BITS - POS_BITS){p[POS_BITS-1]}}, p};
  endfunction

  assign word_accept = word_received & ~word_received_q;  // Rising edge of strobe

  // Control state, settings registers and readback word
  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_q <= 1'b0;
      in_move         <= 1'b0;
      word_count      <= '0;
      mv.load         <= 1'b0;
      enable          <= '0;
      brake           <= '0;
      divisor         <= DEFAULT_CLOCK_DIVISOR;
      word_send_data  <= '0;
    end else begin
      word_received_q <= word_received;
      mv.load         <= 1'b0;

      if (word_accept) begin
        if (!in_move) begin
          case (word_data_received.header.cmd)
            CMD_COORDINATED_STEP: begin
              in_move    <= 1'b1;
              word_count <= WORD_CNT_BITS'(1);
            end
            CMD_MOTOR_ENABLE: enable <= word_data_received.header.payload[NUM_MOTORS-1:0];
            CMD_MOTOR_BRAKE:  brake  <= word_data_received.header.payload[NUM_MOTORS-1:0];
            CMD_CLK_DIVISOR:  divisor <= word_data_received.header.payload[DIVISOR_BITS-1:0];
            CMD_API_VERSION: begin
              word_send_data <= {{(WORD_BITS - 32){1'b0}},
                                 VERSION_DEVEL, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
            end
            default: word_send_data <= '0;
          endcase
        end else begin
          word_count <= word_count + 1'b1;

          // Words 2k+1 and 2k+2 return the snapshot of axis k
          for (int k = 0; k < NUM_MOTORS; k++) begin
            if (int'(word_count) == 2 * k + 1 || int'(word_count) == 2 * k + 2) begin
              word_send_data <= sext_pos(pos_snap[k]);
            end
          end

          if (word_count == WORD_CNT_BITS'(MOVE_WORDS - 1)) begin
            in_move <= 1'b0;   // Back to header
            mv.load <= 1'b1;
          end
        end
      end
    end
  end

  // Move fields and position snapshot
  always_ff @(posedge CLK) begin
    if (word_accept) begin
      if (!in_move) begin
        if (word_data_received.header.cmd == CMD_COORDINATED_STEP) begin
          mv.dir   <= word_data_received.header.payload[NUM_MOTORS-1:0];
          pos_snap <= position;
        end
      end else begin
        if (word_count == WORD_CNT_BITS'(1)) begin
          mv.duration <= word_data_received.data[DURATION_BITS-1:0];
        end
        for (int k = 0; k < NUM_MOTORS; k++) begin
          if (int'(word_count) == 2 * k + 2) begin
            mv.increment[k] <= word_data_received.data;
          end
          if (int'(word_count) == 2 * k + 3) begin
            mv.increment_increment[k] <= word_data_received.data;
          end
        end
      end
    end
  end

  // Words are at least two cycles apart, so commits never merge
  a_load_single: assert property (@(posedge CLK) disable iff (resetn) mv.load |=> !mv.load)
    else $error("Move load held for more than one cycle");

endmodule

`default_nettype wire
